// ==== logic/rv_pkg.sv ====
package rv_pkg;

    //////////////////////////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////////////////////////

    localparam int xlen    = 32;    // Data word width
    localparam int reg_sel = 5;     // Register index width, instr fields

    //////////////////////////////////////////////////////////////////////
    // Opcodes, instr[6:2]
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [4:0] {
        op_load   = 5'b00000,
        op_i      = 5'b00100,   // Register-immediate ALU ops
        op_auipc  = 5'b00101,
        op_store  = 5'b01000,
        op_r      = 5'b01100,   // Register-register ALU ops
        op_lui    = 5'b01101,
        op_branch = 5'b11000,
        op_jalr   = 5'b11001,
        op_jal    = 5'b11011
    } opcode_t;

    // Immediate formats
    typedef enum logic [2:0] {
        r_type   = 3'd0,        // No immediate
        i_type   = 3'd1,
        s_type   = 3'd2,
        b_type   = 3'd3,
        u_type   = 3'd4,
        j_type   = 3'd5,
        nop_type = 3'd6         // Unknown opcode, immediate zero
    } instr_type_t;

    //////////////////////////////////////////////////////////////////////
    // ALU operations
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,        // Also beq/bne compare
        alu_sll  = 4'd2,
        alu_slt  = 4'd3,        // Also blt/bge
        alu_sltu = 4'd4,        // Also bltu/bgeu
        alu_xor  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_or   = 4'd8,
        alu_and  = 4'd9,
        alu_pass = 4'd10        // Operand b straight through, lui
    } alu_op_t;

endpackage

// ==== logic/decode_if.sv ====
`timescale 1ns/1ps

// Decoded instruction, decode to execute
interface decode_if;

    logic                       valid;          // One cycle per instruction
    logic [rv_pkg::xlen-1:0]    pc;
    rv_pkg::alu_op_t            alu_op;
    logic [rv_pkg::xlen-1:0]    data1;          // rs1 contents
    logic [rv_pkg::xlen-1:0]    data2;          // rs2 contents
    logic [rv_pkg::xlen-1:0]    immd;
    logic                       alu_src;        // Operand b from immd
    logic [2:0]                 func3;          // Branch condition select
    logic [rv_pkg::reg_sel-1:0] destination;
    logic                       reg_write;
    logic                       mem_read;
    logic                       mem_write;
    logic                       branch;
    logic                       jump;           // jal or jalr
    logic                       jalr;
    logic                       auipc;          // Operand a from pc

    modport producer (
        output valid, pc, alu_op, data1, data2, immd, alu_src, func3,
               destination, reg_write, mem_read, mem_write, branch, jump, jalr, auipc
    );

    modport consumer (
        input  valid, pc, alu_op, data1, data2, immd, alu_src, func3,
               destination, reg_write, mem_read, mem_write, branch, jump, jalr, auipc
    );

endinterface

// ==== logic/exec_if.sv ====
`timescale 1ns/1ps

// Execute outcome, registered, toward writeback
interface exec_if;

    logic                       valid;          // One-cycle strobe
    logic [rv_pkg::xlen-1:0]    result;         // ALU value, link or address
    logic [rv_pkg::reg_sel-1:0] destination;
    logic                       reg_write;      // Already cleared for loads/stores
    logic                       mem_access;
    logic [rv_pkg::xlen-1:0]    next_pc;

    modport producer (
        output valid, result, destination, reg_write, mem_access, next_pc
    );

    modport consumer (
        input  valid, result, destination, reg_write, mem_access, next_pc
    );

endinterface

// ==== logic/register_file.sv ====
`timescale 1ns/1ps

module register_file #(
    parameter int num_regs  = 32,
    parameter int word_size = 32
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [rv_pkg::reg_sel-1:0] rs1,
    input  logic [rv_pkg::reg_sel-1:0] rs2,
    input  logic                       wr_en,
    input  logic [rv_pkg::reg_sel-1:0] wr_sel,
    input  logic [word_size-1:0]       wr_data,
    output logic [word_size-1:0]       rs1_data,
    output logic [word_size-1:0]       rs2_data
);

    logic [word_size-1:0] regs [num_regs];

    // Combinational reads, indices past the file give zero (RV32E case)
    assign rs1_data = (int'(rs1) < num_regs) ? regs[rs1] : '0;
    assign rs2_data = (int'(rs2) < num_regs) ? regs[rs2] : '0;

    // Same-cycle read sees the old value, write lands on the edge
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_sel != '0 && int'(wr_sel) < num_regs) begin
            regs[wr_sel] <= wr_data;        // x0 never written
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    // Writeback must only target registers this file actually has
    wr_sel_in_range: assert property (
        @(posedge clk) disable iff (reset)
        wr_en |-> int'(wr_sel) < num_regs
    ) else $error("register write to x%0d beyond %0d entries", wr_sel, num_regs);

endmodule

// ==== logic/immediate_gen.sv ====
`timescale 1ns/1ps

module immediate_gen (
    input  logic [rv_pkg::xlen-1:0] instr,
    input  rv_pkg::instr_type_t     instr_type,
    output logic [rv_pkg::xlen-1:0] immd
);

    localparam int xlen = rv_pkg::xlen;

    logic sign;

    assign sign = instr[31];    // Every format keeps its sign in bit 31

    always_comb begin
        case (instr_type)
            rv_pkg::i_type: begin
                immd = {{(xlen-12){sign}}, instr[31:20]};
            end
            rv_pkg::s_type: begin
                immd = {{(xlen-12){sign}}, instr[31:25], instr[11:7]};
            end
            // Branch offset, bit 0 implied zero
            rv_pkg::b_type: begin
                immd = {{(xlen-13){sign}}, sign, instr[7], instr[30:25],
                        instr[11:8], 1'b0};
            end
            rv_pkg::u_type: begin
                immd = {instr[31:12], 12'b0};   // Upper 20 bits, low half clear
            end
            // jal offset, scrambled field order
            rv_pkg::j_type: begin
                immd = {{(xlen-21){sign}}, sign, instr[19:12], instr[20],
                        instr[30:21], 1'b0};
            end
            default: begin
                immd = '0;                      // R-type and nop
            end
        endcase
    end

endmodule

// ==== logic/id_stage.sv ====
`timescale 1ns/1ps

module id_stage #(
    parameter int num_regs  = 32,
    parameter int word_size = 32
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       req,         // Four-phase request
    input  logic [word_size-1:0]       instr,
    input  logic [word_size-1:0]       pc,
    input  logic                       ack,         // From writeback
    input  logic                       wr_en,
    input  logic [rv_pkg::reg_sel-1:0] wr_sel,
    input  logic [word_size-1:0]       wr_data,
    decode_if.producer                 dec
);

    logic [word_size-1:0]       instr_q;
    logic [word_size-1:0]       pc_q;
    logic                       busy;               // Handshake open
    logic                       latched;            // Cycle after capture
    logic [4:0]                 opcode;
    logic [2:0]                 func3;
    logic [rv_pkg::reg_sel-1:0] rs1;
    logic [rv_pkg::reg_sel-1:0] rs2;
    logic [rv_pkg::reg_sel-1:0] destination;
    rv_pkg::alu_op_t            alu_op;
    rv_pkg::instr_type_t        instr_type;

    //////////////////////////////////////////////////////////////////////
    // Request capture
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            busy      <= 1'b0;
            latched   <= 1'b0;
            dec.valid <= 1'b0;
        end else begin
            latched   <= req && !busy;
            dec.valid <= latched;               // Decode window one cycle later
            if (req && !busy)
                busy <= 1'b1;
            else if (!req && ack)
                busy <= 1'b0;                   // Ack drops on this same edge
        end
    end

    always_ff @(posedge clk) begin
        if (req && !busy) begin
            instr_q <= instr;
            pc_q    <= pc;
        end
    end

    register_file #(
        .num_regs  (num_regs),
        .word_size (word_size)
    ) u_regs (
        .clk      (clk),
        .reset    (reset),
        .rs1      (rs1),
        .rs2      (rs2),
        .wr_en    (wr_en),
        .wr_sel   (wr_sel),
        .wr_data  (wr_data),
        .rs1_data (dec.data1),
        .rs2_data (dec.data2)
    );

    immediate_gen u_immd (
        .instr      (instr_q),
        .instr_type (instr_type),
        .immd       (dec.immd)
    );

    //////////////////////////////////////////////////////////////////////
    // Decode
    //////////////////////////////////////////////////////////////////////

    assign opcode = instr_q[6:2];
    assign func3  = instr_q[14:12];

    always_comb begin
        destination = '0;                       // Nop unless proven otherwise
        rs1         = '0;
        rs2         = '0;
        alu_op      = rv_pkg::alu_add;
        instr_type  = rv_pkg::nop_type;
        case (opcode)
            rv_pkg::op_r, rv_pkg::op_i, rv_pkg::op_jalr: begin
                instr_type  = (opcode == rv_pkg::op_r) ? rv_pkg::r_type : rv_pkg::i_type;
                destination = instr_q[11:7];
                rs1         = instr_q[19:15];
                rs2         = (opcode == rv_pkg::op_r) ? instr_q[24:20] : '0;
                case (func3)
                    3'b000: begin
                        // Bit 30 picks sub, R-type only
                        if (opcode == rv_pkg::op_r && instr_q[30])
                            alu_op = rv_pkg::alu_sub;
                        else
                            alu_op = rv_pkg::alu_add;   // add, addi, jalr target
                    end
                    3'b001: alu_op = rv_pkg::alu_sll;
                    3'b010: alu_op = rv_pkg::alu_slt;
                    3'b011: alu_op = rv_pkg::alu_sltu;
                    3'b100: alu_op = rv_pkg::alu_xor;
                    3'b101: alu_op = instr_q[30] ? rv_pkg::alu_sra : rv_pkg::alu_srl;
                    3'b110: alu_op = rv_pkg::alu_or;
                    default: alu_op = rv_pkg::alu_and;
                endcase
                if (opcode == rv_pkg::op_jalr)
                    alu_op = rv_pkg::alu_add;   // Target ignores func3
            end
            rv_pkg::op_load: begin
                instr_type  = rv_pkg::i_type;
                destination = instr_q[11:7];    // Dropped later, no data memory
                rs1         = instr_q[19:15];
            end
            rv_pkg::op_store: begin
                instr_type = rv_pkg::s_type;
                rs1        = instr_q[19:15];
                rs2        = instr_q[24:20];
            end
            rv_pkg::op_branch: begin
                instr_type = rv_pkg::b_type;
                rs1        = instr_q[19:15];
                rs2        = instr_q[24:20];
                case (func3[2:1])
                    2'b10:   alu_op = rv_pkg::alu_slt;  // blt, bge
                    2'b11:   alu_op = rv_pkg::alu_sltu; // bltu, bgeu
                    default: alu_op = rv_pkg::alu_sub;  // beq, bne
                endcase
            end
            rv_pkg::op_lui, rv_pkg::op_auipc: begin
                instr_type  = rv_pkg::u_type;
                destination = instr_q[11:7];
                alu_op      = (opcode == rv_pkg::op_lui) ? rv_pkg::alu_pass
                                                         : rv_pkg::alu_add;
            end
            rv_pkg::op_jal: begin
                instr_type  = rv_pkg::j_type;
                destination = instr_q[11:7];
            end
            default: ;
        endcase
    end

    assign dec.pc          = pc_q;
    assign dec.alu_op      = alu_op;
    assign dec.func3       = func3;
    assign dec.destination = destination;
    assign dec.reg_write   = (destination != '0);
    assign dec.mem_read    = (opcode == rv_pkg::op_load);
    assign dec.mem_write   = (instr_type == rv_pkg::s_type);
    assign dec.alu_src     = (instr_type != rv_pkg::r_type && instr_type != rv_pkg::b_type);
    assign dec.branch      = (instr_type == rv_pkg::b_type);
    assign dec.jump        = (instr_type == rv_pkg::j_type || opcode == rv_pkg::op_jalr);
    assign dec.jalr        = (opcode == rv_pkg::op_jalr);
    assign dec.auipc       = (opcode == rv_pkg::op_auipc);

    // Decode window sits inside an open handshake, ahead of its ack
    valid_in_handshake: assert property (
        @(posedge clk) disable iff (reset)
        dec.valid |-> busy && !ack
    ) else $error("decode valid outside an open handshake");

endmodule

// ==== logic/alu_execute.sv ====
`timescale 1ns/1ps

module alu_execute (
    input  logic       clk,
    input  logic       reset,
    decode_if.consumer dec,
    exec_if.producer   exe
);

    localparam int xlen    = rv_pkg::xlen;
    localparam int shamt_w = $clog2(xlen);

    logic [xlen-1:0]    op_a;
    logic [xlen-1:0]    op_b;
    logic [shamt_w-1:0] shamt;
    logic [xlen-1:0]    alu_y;
    logic [xlen-1:0]    pc_plus4;
    logic [xlen-1:0]    br_target;
    logic [xlen-1:0]    next_pc;
    logic               cond;
    logic               taken;

    // pc feeds operand a for auipc and jal
    assign op_a  = (dec.auipc || (dec.jump && !dec.jalr)) ? dec.pc : dec.data1;
    assign op_b  = dec.alu_src ? dec.immd : dec.data2;
    assign shamt = op_b[shamt_w-1:0];

    always_comb begin
        case (dec.alu_op)
            rv_pkg::alu_add:  alu_y = op_a + op_b;
            rv_pkg::alu_sub:  alu_y = op_a - op_b;
            rv_pkg::alu_sll:  alu_y = op_a << shamt;
            rv_pkg::alu_slt:  alu_y = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            rv_pkg::alu_sltu: alu_y = {{(xlen-1){1'b0}}, op_a < op_b};
            rv_pkg::alu_xor:  alu_y = op_a ^ op_b;
            rv_pkg::alu_srl:  alu_y = op_a >> shamt;
            rv_pkg::alu_sra:  alu_y = $unsigned($signed(op_a) >>> shamt);
            rv_pkg::alu_or:   alu_y = op_a | op_b;
            rv_pkg::alu_and:  alu_y = op_a & op_b;
            rv_pkg::alu_pass: alu_y = op_b;
            default:          alu_y = '0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Branch and next pc
    //////////////////////////////////////////////////////////////////////

    assign pc_plus4  = dec.pc + xlen'(4);
    assign br_target = dec.pc + dec.immd;

    // Compare result, odd func3 inverts the sense
    assign cond  = dec.func3[2] ? alu_y[0] : (alu_y == '0);
    assign taken = dec.branch && (cond ^ dec.func3[0]);

    always_comb begin
        if (dec.jalr)
            next_pc = {alu_y[xlen-1:1], 1'b0};  // rs1+imm, bit 0 dropped
        else if (dec.jump || taken)
            next_pc = br_target;                // jal or taken branch
        else
            next_pc = pc_plus4;
    end

    always_ff @(posedge clk) begin
        if (reset)
            exe.valid <= 1'b0;
        else
            exe.valid <= dec.valid;
    end

    // Payload, meaningful only with valid
    always_ff @(posedge clk) begin
        exe.result      <= dec.jump ? pc_plus4 : alu_y;     // Link address on jumps
        exe.destination <= dec.destination;
        exe.reg_write   <= dec.reg_write && !(dec.mem_read || dec.mem_write);
        exe.mem_access  <= dec.mem_read || dec.mem_write;
        exe.next_pc     <= next_pc;
    end

endmodule

// ==== logic/writeback_result.sv ====
`timescale 1ns/1ps

module writeback_result (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       req,
    exec_if.consumer                   exe,
    output logic                       ack,
    output logic [rv_pkg::xlen-1:0]    result,
    output logic [rv_pkg::reg_sel-1:0] rd,
    output logic                       rd_write,
    output logic [rv_pkg::xlen-1:0]    next_pc,
    output logic                       mem_access,
    output logic                       wr_en,       // Register file write port
    output logic [rv_pkg::reg_sel-1:0] wr_sel,
    output logic [rv_pkg::xlen-1:0]    wr_data
);

    // Write lands on the edge that samples exe.valid
    assign wr_en   = exe.valid && exe.reg_write;
    assign wr_sel  = exe.destination;
    assign wr_data = exe.result;

    // Holding registers, stable for the whole ack phase
    always_ff @(posedge clk) begin
        if (exe.valid) begin
            result     <= exe.result;
            rd         <= exe.destination;
            rd_write   <= exe.reg_write;
            next_pc    <= exe.next_pc;
            mem_access <= exe.mem_access;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Ack side of the four-phase handshake
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset)
            ack <= 1'b0;
        else if (exe.valid)
            ack <= 1'b1;
        else if (ack && !req)
            ack <= 1'b0;            // Requester done, close
    end

    // Ack only ever answers a live request
    ack_needs_req: assert property (
        @(posedge clk) disable iff (reset)
        $rose(ack) |-> $past(req)
    ) else $error("ack raised with req low");

endmodule

// ==== logic/rv_core_top.sv ====
`timescale 1ns/1ps

module rv_core_top #(
    parameter int num_regs  = 32,           // 16 also fine, RV32E
    parameter int word_size = rv_pkg::xlen
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       req,
    input  logic [word_size-1:0]       instr,
    input  logic [word_size-1:0]       pc,
    output logic                       ack,
    output logic [word_size-1:0]       result,
    output logic [rv_pkg::reg_sel-1:0] rd,
    output logic                       rd_write,
    output logic [word_size-1:0]       next_pc,
    output logic                       mem_access
);

    logic                       wr_en;      // Writeback back into decode's file
    logic [rv_pkg::reg_sel-1:0] wr_sel;
    logic [word_size-1:0]       wr_data;

    decode_if dec_bus ();
    exec_if   exe_bus ();

    id_stage #(
        .num_regs  (num_regs),
        .word_size (word_size)
    ) u_id (
        .clk     (clk),
        .reset   (reset),
        .req     (req),
        .instr   (instr),
        .pc      (pc),
        .ack     (ack),
        .wr_en   (wr_en),
        .wr_sel  (wr_sel),
        .wr_data (wr_data),
        .dec     (dec_bus)
    );

    alu_execute u_ex (
        .clk   (clk),
        .reset (reset),
        .dec   (dec_bus),
        .exe   (exe_bus)
    );

    writeback_result u_wb (
        .clk        (clk),
        .reset      (reset),
        .req        (req),
        .exe        (exe_bus),
        .ack        (ack),
        .result     (result),
        .rd         (rd),
        .rd_write   (rd_write),
        .next_pc    (next_pc),
        .mem_access (mem_access),
        .wr_en      (wr_en),
        .wr_sel     (wr_sel),
        .wr_data    (wr_data)
    );

endmodule

// ==== testbench/tb_rv_core.sv ====
`timescale 1ns/1ps

module tb_rv_core;

    localparam int num_random      = 600;      // Random instructions, split around a reset
    localparam int num_readback    = 31;       // x1..x31 read after the mid-run reset
    localparam int watchdog_cycles = (num_random + num_readback) * 10 + 30;

    logic        clk;
    logic        reset;
    logic        req;
    logic [31:0] instr;
    logic [31:0] pc;
    logic        ack;
    logic [31:0] result;
    logic [4:0]  rd;
    logic        rd_write;
    logic [31:0] next_pc;
    logic        mem_access;

    logic [31:0] model_regs [32];               // Reference register file
    logic        req_seen   = 1'b0;             // req as sampled by the last edge
    logic        reset_seen = 1'b1;
    int          checks     = 0;
    int          mismatches = 0;
    int          faults     = 0;                // Handshake errors

    rv_core_top #(.num_regs(32), .word_size(32)) uut (
        .clk(clk), .reset(reset), .req(req), .instr(instr), .pc(pc),
        .ack(ack), .result(result), .rd(rd), .rd_write(rd_write),
        .next_pc(next_pc), .mem_access(mem_access)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;                 // 100 ns period
    end

    //////////////////////////////////////////////////////////////////////
    // Checking helpers
    //////////////////////////////////////////////////////////////////////

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            mismatches++;
            $display("mismatch at %0t: %s got %08h expected %08h", $time, what, got, exp);
        end
    endtask

    task automatic check_protocol(input logic ok, input string msg);
        checks++;
        assert (ok) else begin
            faults++;
            $display("protocol error at %0t: %s", $time, msg);
        end
    endtask

    // No ack without a live request
    always @(posedge clk) begin
        req_seen   <= req;
        reset_seen <= reset;
    end

    always @(negedge clk) begin
        if (!reset_seen)
            check_protocol(!ack || req_seen, "ack high although req was low at the last edge");
    end

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] alu(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;   // sub only with bit 30
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: begin
                if (alt)
                    return $unsigned($signed(a) >>> b[4:0]);   // Arithmetic
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic void predict(input logic [31:0] ins, input logic [31:0] pcv,
            output logic [31:0] res, output logic [31:0] nxt, output logic [4:0] rdv,
            output logic wr, output logic mem, output logic res_known);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        logic [2:0]  f3;
        logic        taken;
        a         = model_regs[ins[19:15]];
        b         = model_regs[ins[24:20]];
        f3        = ins[14:12];
        imm_i     = {{20{ins[31]}}, ins[31:20]};
        imm_s     = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b     = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_j     = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        res       = 32'h0;
        nxt       = pcv + 32'd4;
        rdv       = ins[11:7];
        mem       = 1'b0;
        res_known = 1'b1;
        taken     = 1'b0;
        case (ins[6:0])
            7'b0110011: res = alu(f3, ins[30], a, b);                       // R
            7'b0010011: res = alu(f3, f3 == 3'd5 && ins[30], a, imm_i);     // I
            7'b0000011: begin                   // Load, address only
                res = a + imm_i;
                mem = 1'b1;
            end
            7'b0100011: begin                   // Store
                res = a + imm_s;
                mem = 1'b1;
                rdv = 5'd0;
            end
            7'b1100011: begin
                rdv       = 5'd0;
                res_known = 1'b0;               // Compare value not architectural
                case (f3)
                    3'd0: taken = (a == b);
                    3'd1: taken = (a != b);
                    3'd4: taken = $signed(a) < $signed(b);
                    3'd5: taken = $signed(a) >= $signed(b);
                    3'd6: taken = a < b;
                    default: taken = a >= b;
                endcase
                if (taken)
                    nxt = pcv + imm_b;
            end
            7'b0110111: res = {ins[31:12], 12'b0};          // lui
            7'b0010111: res = pcv + {ins[31:12], 12'b0};    // auipc
            7'b1101111: begin                   // jal
                res = pcv + 32'd4;
                nxt = pcv + imm_j;
            end
            7'b1100111: begin                   // jalr
                res = pcv + 32'd4;
                nxt = (a + imm_i) & ~32'h1;
            end
            default: rdv = 5'd0;                // Unknown, acts as nop
        endcase
        wr = (rdv != 5'd0) && !mem;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    function automatic logic known_opcode(input logic [4:0] op);
        case (op)
            5'b00000, 5'b00100, 5'b00101, 5'b01000, 5'b01100,
            5'b01101, 5'b11000, 5'b11001, 5'b11011: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] random_instr();
        logic [31:0] ins;
        logic [2:0]  f3;
        logic [4:0]  op;
        int          kind;
        ins      = $urandom;                    // Random fields, then fix up
        ins[1:0] = 2'b11;
        f3       = ins[14:12];
        kind     = $urandom_range(0, 12);
        case (kind)
            0, 1: begin
                ins[6:2]   = 5'b01100;
                ins[31:25] = ((f3 == 3'd0 || f3 == 3'd5) && ins[30]) ? 7'h20 : 7'h00;
            end
            2, 3: begin
                ins[6:2] = 5'b00100;
                if (f3 == 3'd1)
                    ins[31:25] = 7'h00;         // slli
                else if (f3 == 3'd5)
                    ins[31:25] = ins[30] ? 7'h20 : 7'h00;   // srai or srli
            end
            4: ins[6:2] = 5'b00000;
            5: ins[6:2] = 5'b01000;
            6, 7: begin
                ins[6:2] = 5'b11000;
                f3       = 3'($urandom_range(0, 5));
                if (f3 >= 3'd2)
                    f3 = f3 + 3'd2;             // Skip the two unused codes
                ins[14:12] = f3;
                if ($urandom_range(0, 3) == 0)
                    ins[24:20] = ins[19:15];    // Equal operands now and then
            end
            8:  ins[6:2] = 5'b01101;
            9:  ins[6:2] = 5'b00101;
            10: ins[6:2] = 5'b11011;
            11: begin
                ins[6:2]   = 5'b11001;
                ins[14:12] = 3'b000;
            end
            default: begin
                op = 5'($urandom_range(0, 31));
                while (known_opcode(op))
                    op = 5'($urandom_range(0, 31));
                ins[6:2] = op;
            end
        endcase
        if ($urandom_range(0, 7) == 0)
            ins[11:7] = 5'd0;                   // x0 destination
        return ins;
    endfunction

    // One full four-phase handshake, entered and left on a falling edge
    task automatic run_instr(input logic [31:0] ins, input logic [31:0] pcv);
        logic [31:0] exp_res;
        logic [31:0] exp_next;
        logic [4:0]  exp_rd;
        logic        exp_wr;
        logic        exp_mem;
        logic        res_known;
        int          edges;
        predict(ins, pcv, exp_res, exp_next, exp_rd, exp_wr, exp_mem, res_known);
        check_protocol(!ack, "ack high before the request");
        instr = ins;
        pc    = pcv;
        req   = 1'b1;
        edges = 0;
        while (!ack && edges < 8) begin
            @(negedge clk);
            edges++;
        end
        if (!ack) begin
            check_protocol(1'b0, "no ack within 8 cycles of req");
            req = 1'b0;
            repeat (4) @(negedge clk);
            return;
        end
        check_protocol(edges == 4, $sformatf("ack came %0d edges after req, not 3", edges - 1));
        if (res_known)
            check_value("result", result, exp_res);
        check_value("next_pc", next_pc, exp_next);
        check_value("rd", 32'(rd), 32'(exp_rd));
        check_value("rd_write", 32'(rd_write), 32'(exp_wr));
        check_value("mem_access", 32'(mem_access), 32'(exp_mem));
        @(negedge clk);
        check_protocol(ack, "ack fell while req still high");
        req = 1'b0;
        @(negedge clk);
        check_protocol(!ack, "ack still high one edge after req dropped");
        if (exp_wr)
            model_regs[exp_rd] = exp_res;
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        req   = 1'b0;                           // Abandons any open handshake
        repeat (10) @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i < 32; i++)
            model_regs[i] = 32'h0;
        check_protocol(!ack, "ack high right after reset");
    endtask

    initial begin
        void'($urandom(32'heae3));
        req   = 1'b0;
        instr = 32'h0;
        pc    = 32'h0;
        apply_reset();
        for (int i = 0; i < num_random / 2; i++)
            run_instr(random_instr(), $urandom & 32'hffff_fffc);
        // Mid-run reset while ack is high
        req = 1'b1;
        while (!ack)
            @(negedge clk);
        apply_reset();
        for (int r = 1; r <= num_readback; r++)   // add x0, xr, x0 must give zero
            run_instr({12'h000, 5'(r), 3'b000, 5'd0, 7'b0110011}, $urandom & 32'hffff_fffc);
        for (int i = 0; i < num_random / 2; i++)
            run_instr(random_instr(), $urandom & 32'hffff_fffc);
        $display("checks %0d, mismatches %0d, protocol errors %0d", checks, mismatches, faults);
        if (mismatches == 0 && faults == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", watchdog_cycles);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// ==== project.f ====
logic/rv_pkg.sv
logic/decode_if.sv
logic/exec_if.sv
logic/register_file.sv
logic/immediate_gen.sv
logic/id_stage.sv
logic/alu_execute.sv
logic/writeback_result.sv
logic/rv_core_top.sv
testbench/tb_rv_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the RV32I decode subsystem testbench with Verilator, run it, log to sim.log
# Exit status is nonzero when the log holds the fail message or no result

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_rv_core -f project.f -o tb_rv_core > sim.log 2>&1 &&
    ./obj_dir/tb_rv_core >> sim.log 2>&1 ||
    echo "build or simulation exited with an error, RESULT: FAIL" >> sim.log

grep -q "RESULT: FAIL" sim.log && { echo "Simulation FAILED, see sim.log"; exit 1; }
grep -q "RESULT: PASS" sim.log || { echo "No result found in sim.log"; exit 1; }
echo "Simulation passed"
